// File: rtl/soc_pkg.sv
package soc_pkg;

	// Bus payload types
	typedef logic [31:0] addr_t;
	typedef logic [31:0] data_t;
	typedef logic [3:0]  strb_t;
	typedef logic [1:0]  resp_t;

	// GPIO pins, led_o covers both LED banks
	typedef logic [7:0] led_t;
	typedef logic [3:0] sw_t;

	localparam resp_t RESP_OKAY   = 2'b00;
	localparam resp_t RESP_DECERR = 2'b11;

	// Memory map, the memory end follows from the memory size
	localparam addr_t MEM_START_ADDRESS  = 32'h0000_0000;
	localparam addr_t GPIO_START_ADDRESS = 32'h1000_0000;
	localparam int    GPIO_SPAN          = 16; // Bytes

	// Register offset inside the GPIO window
	typedef logic [$clog2(GPIO_SPAN)-1:0] gpio_off_t;

	localparam gpio_off_t GPIO_SW_OFFSET  = 'h0; // Read only
	localparam gpio_off_t GPIO_LED_OFFSET = 'h4;

endpackage

// File: rtl/axi_crossbar.sv
`timescale 1ns/1ns

module axi_crossbar import soc_pkg::*; #(
	parameter int MEM_ADDR_SIZE = 10
) (
	input  logic  clk_i,
	input  logic  rst_n_i,
	input  addr_t s_awaddr_i,
	input  logic  s_awvalid_i,
	output logic  s_awready_o,
	input  data_t s_wdata_i,
	input  strb_t s_wstrb_i,
	input  logic  s_wvalid_i,
	output logic  s_wready_o,
	output resp_t s_bresp_o,
	output logic  s_bvalid_o,
	input  logic  s_bready_i,
	input  addr_t s_araddr_i,
	input  logic  s_arvalid_i,
	output logic  s_arready_o,
	output data_t s_rdata_o,
	output resp_t s_rresp_o,
	output logic  s_rvalid_o,
	input  logic  s_rready_i,
	output addr_t mem_awaddr_o,
	output logic  mem_awvalid_o,
	input  logic  mem_awready_i,
	output data_t mem_wdata_o,
	output strb_t mem_wstrb_o,
	output logic  mem_wvalid_o,
	input  logic  mem_wready_i,
	input  resp_t mem_bresp_i,
	input  logic  mem_bvalid_i,
	output logic  mem_bready_o,
	output addr_t mem_araddr_o,
	output logic  mem_arvalid_o,
	input  logic  mem_arready_i,
	input  data_t mem_rdata_i,
	input  resp_t mem_rresp_i,
	input  logic  mem_rvalid_i,
	output logic  mem_rready_o,
	output addr_t gpio_awaddr_o,
	output logic  gpio_awvalid_o,
	input  logic  gpio_awready_i,
	output data_t gpio_wdata_o,
	output strb_t gpio_wstrb_o,
	output logic  gpio_wvalid_o,
	input  logic  gpio_wready_i,
	input  resp_t gpio_bresp_i,
	input  logic  gpio_bvalid_i,
	output logic  gpio_bready_o,
	output addr_t gpio_araddr_o,
	output logic  gpio_arvalid_o,
	input  logic  gpio_arready_i,
	input  data_t gpio_rdata_i,
	input  resp_t gpio_rresp_i,
	input  logic  gpio_rvalid_i,
	output logic  gpio_rready_o
);

	// Memory holds 2**MEM_ADDR_SIZE words of 4 bytes
	localparam addr_t MEM_END_ADDRESS =
		MEM_START_ADDRESS + (addr_t'(1) << (MEM_ADDR_SIZE + 2)) - addr_t'(1);
	localparam addr_t GPIO_END_ADDRESS = GPIO_START_ADDRESS + addr_t'(GPIO_SPAN) - addr_t'(1);

	typedef enum logic [2:0] {IDLE, WRITE_FWD, READ_FWD, WAIT_RESP, DEC_ERR, RESP} state_e;
	typedef enum logic [1:0] {TGT_NONE, TGT_MEM, TGT_GPIO} target_e;

	state_e  state_q, state_d;
	target_e tgt_q, req_tgt;
	logic    is_write_q;
	addr_t   addr_q;
	data_t   wdata_q, rdata_q;
	strb_t   wstrb_q;
	resp_t   resp_q;
	logic    wr_accept, rd_accept, resp_done;
	logic    sel_mem, sel_gpio, fwd_wr, fwd_rd, take_b, take_r;
	logic    ep_wr_ready, ep_ar_ready, ep_bvalid, ep_rvalid;
	resp_t   ep_bresp, ep_rresp;
	data_t   ep_rdata;

	function automatic target_e decode(addr_t addr);
		if (addr >= MEM_START_ADDRESS && addr <= MEM_END_ADDRESS)
			return TGT_MEM;
		if (addr >= GPIO_START_ADDRESS && addr <= GPIO_END_ADDRESS)
			return TGT_GPIO;
		return TGT_NONE;
	endfunction

	// Write wins over a read in the same idle cycle
	assign wr_accept = (state_q == IDLE) && s_awvalid_i && s_wvalid_i;
	assign rd_accept = (state_q == IDLE) && s_arvalid_i && !wr_accept;
	assign req_tgt   = wr_accept ? decode(s_awaddr_i) : decode(s_araddr_i);

	assign s_awready_o = wr_accept;
	assign s_wready_o  = wr_accept;
	assign s_arready_o = rd_accept;

	assign sel_mem  = (tgt_q == TGT_MEM);
	assign sel_gpio = (tgt_q == TGT_GPIO);

	// Response of the selected endpoint
	assign ep_wr_ready = sel_mem ? (mem_awready_i && mem_wready_i)
	                             : (gpio_awready_i && gpio_wready_i);
	assign ep_ar_ready = sel_mem ? mem_arready_i : gpio_arready_i;
	assign ep_bvalid   = sel_mem ? mem_bvalid_i  : gpio_bvalid_i;
	assign ep_bresp    = sel_mem ? mem_bresp_i   : gpio_bresp_i;
	assign ep_rvalid   = sel_mem ? mem_rvalid_i  : gpio_rvalid_i;
	assign ep_rdata    = sel_mem ? mem_rdata_i   : gpio_rdata_i;
	assign ep_rresp    = sel_mem ? mem_rresp_i   : gpio_rresp_i;

	assign resp_done = is_write_q ? s_bready_i : s_rready_i;

	always_comb begin
		state_d = state_q;
		unique case (state_q)
			IDLE: begin
				if (wr_accept)
					state_d = (req_tgt == TGT_NONE) ? DEC_ERR : WRITE_FWD;
				else if (rd_accept)
					state_d = (req_tgt == TGT_NONE) ? DEC_ERR : READ_FWD;
			end
			WRITE_FWD: if (ep_wr_ready) state_d = WAIT_RESP;
			READ_FWD:  if (ep_ar_ready) state_d = WAIT_RESP;
			WAIT_RESP: if (is_write_q ? ep_bvalid : ep_rvalid) state_d = RESP;
			DEC_ERR, RESP: if (resp_done) state_d = IDLE;
			default: state_d = IDLE;
		endcase
	end

	always_ff @(posedge clk_i) begin
		if (!rst_n_i) begin
			state_q    <= IDLE;
			tgt_q      <= TGT_NONE;
			is_write_q <= 1'b0;
		end else begin
			state_q <= state_d;
			if (wr_accept || rd_accept) begin
				tgt_q      <= req_tgt;
				is_write_q <= wr_accept;
			end
		end
	end

	always_ff @(posedge clk_i) begin
		if (wr_accept) begin
			addr_q  <= s_awaddr_i;
			wdata_q <= s_wdata_i;
			wstrb_q <= s_wstrb_i;
		end else if (rd_accept) begin
			addr_q <= s_araddr_i;
		end
		// Capture the endpoint answer so it can be held for the master
		if (take_b || take_r) begin
			resp_q  <= is_write_q ? ep_bresp : ep_rresp;
			rdata_q <= is_write_q ? '0 : ep_rdata;
		end
	end

	assign fwd_wr = (state_q == WRITE_FWD);
	assign fwd_rd = (state_q == READ_FWD);
	assign take_b = (state_q == WAIT_RESP) && is_write_q && ep_bvalid;
	assign take_r = (state_q == WAIT_RESP) && !is_write_q && ep_rvalid;

	assign mem_awaddr_o  = addr_q;
	assign mem_araddr_o  = addr_q;
	assign mem_wdata_o   = wdata_q;
	assign mem_wstrb_o   = wstrb_q;
	assign mem_awvalid_o = fwd_wr && sel_mem;
	assign mem_wvalid_o  = fwd_wr && sel_mem;
	assign mem_arvalid_o = fwd_rd && sel_mem;
	assign mem_bready_o  = (state_q == WAIT_RESP) && is_write_q && sel_mem;
	assign mem_rready_o  = (state_q == WAIT_RESP) && !is_write_q && sel_mem;

	assign gpio_awaddr_o  = addr_q;
	assign gpio_araddr_o  = addr_q;
	assign gpio_wdata_o   = wdata_q;
	assign gpio_wstrb_o   = wstrb_q;
	assign gpio_awvalid_o = fwd_wr && sel_gpio;
	assign gpio_wvalid_o  = fwd_wr && sel_gpio;
	assign gpio_arvalid_o = fwd_rd && sel_gpio;
	assign gpio_bready_o  = (state_q == WAIT_RESP) && is_write_q && sel_gpio;
	assign gpio_rready_o  = (state_q == WAIT_RESP) && !is_write_q && sel_gpio;

	// Unmapped access answers straight from DEC_ERR
	assign s_bvalid_o = is_write_q && (state_q == RESP || state_q == DEC_ERR);
	assign s_rvalid_o = !is_write_q && (state_q == RESP || state_q == DEC_ERR);
	assign s_bresp_o  = (state_q == DEC_ERR) ? RESP_DECERR : resp_q;
	assign s_rresp_o  = (state_q == DEC_ERR) ? RESP_DECERR : resp_q;
	assign s_rdata_o  = (state_q == DEC_ERR) ? '0 : rdata_q;

endmodule

// File: rtl/bram_axi.sv
`timescale 1ns/1ns

module bram_axi import soc_pkg::*; #(
	parameter int MEM_ADDR_SIZE = 10
) (
	input  logic  clk_i,
	input  logic  rst_n_i,
	input  addr_t awaddr_i,
	input  logic  awvalid_i,
	output logic  awready_o,
	input  data_t wdata_i,
	input  strb_t wstrb_i,
	input  logic  wvalid_i,
	output logic  wready_o,
	output resp_t bresp_o,
	output logic  bvalid_o,
	input  logic  bready_i,
	input  addr_t araddr_i,
	input  logic  arvalid_i,
	output logic  arready_o,
	output data_t rdata_o,
	output resp_t rresp_o,
	output logic  rvalid_o,
	input  logic  rready_i
);

	typedef logic [MEM_ADDR_SIZE-1:0] word_idx_t;

	data_t     mem [2**MEM_ADDR_SIZE];
	word_idx_t widx, ridx;
	logic      busy, wr_go, rd_go;

	assign widx = awaddr_i[MEM_ADDR_SIZE+1:2]; // Word index, byte bits dropped
	assign ridx = araddr_i[MEM_ADDR_SIZE+1:2];

	// Nothing new is taken while a response waits
	assign busy  = bvalid_o || rvalid_o;
	assign wr_go = awvalid_i && wvalid_i && !busy;
	assign rd_go = arvalid_i && !busy && !wr_go;

	assign awready_o = wr_go;
	assign wready_o  = wr_go;
	assign arready_o = rd_go;
	assign bresp_o   = RESP_OKAY;
	assign rresp_o   = RESP_OKAY;

	always_ff @(posedge clk_i) begin
		if (wr_go) begin
			for (int i = 0; i < $bits(strb_t); i++) begin
				if (wstrb_i[i])
					mem[widx][8*i +: 8] <= wdata_i[8*i +: 8];
			end
		end
		if (rd_go)
			rdata_o <= mem[ridx];
	end

	always_ff @(posedge clk_i) begin
		if (!rst_n_i) begin
			bvalid_o <= 1'b0;
			rvalid_o <= 1'b0;
		end else begin
			if (wr_go)
				bvalid_o <= 1'b1;
			else if (bvalid_o && bready_i)
				bvalid_o <= 1'b0;
			if (rd_go)
				rvalid_o <= 1'b1;
			else if (rvalid_o && rready_i)
				rvalid_o <= 1'b0;
		end
	end

endmodule

// File: rtl/gpio_axi.sv
`timescale 1ns/1ns

module gpio_axi import soc_pkg::*; (
	input  logic  clk_i,
	input  logic  rst_n_i,
	input  addr_t awaddr_i,
	input  logic  awvalid_i,
	output logic  awready_o,
	input  data_t wdata_i,
	input  strb_t wstrb_i, // LED writes take the whole byte regardless
	input  logic  wvalid_i,
	output logic  wready_o,
	output resp_t bresp_o,
	output logic  bvalid_o,
	input  logic  bready_i,
	input  addr_t araddr_i,
	input  logic  arvalid_i,
	output logic  arready_o,
	output data_t rdata_o,
	output resp_t rresp_o,
	output logic  rvalid_o,
	input  logic  rready_i,
	input  sw_t   sw_i,
	output led_t  led_o
);

	gpio_off_t woff, roff;
	sw_t       sw_meta, sw_sync;
	logic      busy, wr_go, rd_go;

	assign woff = gpio_off_t'(awaddr_i);
	assign roff = gpio_off_t'(araddr_i);

	assign busy  = bvalid_o || rvalid_o;
	assign wr_go = awvalid_i && wvalid_i && !busy;
	assign rd_go = arvalid_i && !busy && !wr_go;

	assign awready_o = wr_go;
	assign wready_o  = wr_go;
	assign arready_o = rd_go;
	assign bresp_o   = RESP_OKAY;
	assign rresp_o   = RESP_OKAY;

	// Switches are asynchronous to clk_i
	always_ff @(posedge clk_i) begin
		sw_meta <= sw_i;
		sw_sync <= sw_meta;
	end

	always_ff @(posedge clk_i) begin
		if (rd_go) begin
			unique case (roff)
				GPIO_SW_OFFSET:  rdata_o <= data_t'(sw_sync);
				GPIO_LED_OFFSET: rdata_o <= data_t'(led_o);
				default:         rdata_o <= '0;
			endcase
		end
	end

	always_ff @(posedge clk_i) begin
		if (!rst_n_i) begin
			led_o    <= '0;
			bvalid_o <= 1'b0;
			rvalid_o <= 1'b0;
		end else begin
			if (wr_go && woff == GPIO_LED_OFFSET)
				led_o <= led_t'(wdata_i);
			if (wr_go)
				bvalid_o <= 1'b1;
			else if (bvalid_o && bready_i)
				bvalid_o <= 1'b0;
			if (rd_go)
				rvalid_o <= 1'b1;
			else if (rvalid_o && rready_i)
				rvalid_o <= 1'b0;
		end
	end

endmodule

// File: rtl/soc_top.sv
`timescale 1ns/1ns

module soc_top import soc_pkg::*; (
	input  logic  clk_i,
	input  logic  rst_n_i,
	input  addr_t s_awaddr_i,
	input  logic  s_awvalid_i,
	output logic  s_awready_o,
	input  data_t s_wdata_i,
	input  strb_t s_wstrb_i,
	input  logic  s_wvalid_i,
	output logic  s_wready_o,
	output resp_t s_bresp_o,
	output logic  s_bvalid_o,
	input  logic  s_bready_i,
	input  addr_t s_araddr_i,
	input  logic  s_arvalid_i,
	output logic  s_arready_o,
	output data_t s_rdata_o,
	output resp_t s_rresp_o,
	output logic  s_rvalid_o,
	input  logic  s_rready_i,
	input  sw_t   sw_i,
	output led_t  led_o
);

	localparam int MEM_ADDR_SIZE = 10; // 1024 words

	addr_t mem_awaddr, mem_araddr, gpio_awaddr, gpio_araddr;
	data_t mem_wdata, mem_rdata, gpio_wdata, gpio_rdata;
	strb_t mem_wstrb, gpio_wstrb;
	resp_t mem_bresp, mem_rresp, gpio_bresp, gpio_rresp;
	logic  mem_awvalid, mem_awready, mem_wvalid, mem_wready, mem_bvalid, mem_bready;
	logic  mem_arvalid, mem_arready, mem_rvalid, mem_rready;
	logic  gpio_awvalid, gpio_awready, gpio_wvalid, gpio_wready, gpio_bvalid, gpio_bready;
	logic  gpio_arvalid, gpio_arready, gpio_rvalid, gpio_rready;

	// Slave side and clock/reset connect by name
	axi_crossbar #(.MEM_ADDR_SIZE(MEM_ADDR_SIZE)) crossbar (
		.mem_awaddr_o(mem_awaddr),
		.mem_awvalid_o(mem_awvalid),
		.mem_awready_i(mem_awready),
		.mem_wdata_o(mem_wdata),
		.mem_wstrb_o(mem_wstrb),
		.mem_wvalid_o(mem_wvalid),
		.mem_wready_i(mem_wready),
		.mem_bresp_i(mem_bresp),
		.mem_bvalid_i(mem_bvalid),
		.mem_bready_o(mem_bready),
		.mem_araddr_o(mem_araddr),
		.mem_arvalid_o(mem_arvalid),
		.mem_arready_i(mem_arready),
		.mem_rdata_i(mem_rdata),
		.mem_rresp_i(mem_rresp),
		.mem_rvalid_i(mem_rvalid),
		.mem_rready_o(mem_rready),
		.gpio_awaddr_o(gpio_awaddr),
		.gpio_awvalid_o(gpio_awvalid),
		.gpio_awready_i(gpio_awready),
		.gpio_wdata_o(gpio_wdata),
		.gpio_wstrb_o(gpio_wstrb),
		.gpio_wvalid_o(gpio_wvalid),
		.gpio_wready_i(gpio_wready),
		.gpio_bresp_i(gpio_bresp),
		.gpio_bvalid_i(gpio_bvalid),
		.gpio_bready_o(gpio_bready),
		.gpio_araddr_o(gpio_araddr),
		.gpio_arvalid_o(gpio_arvalid),
		.gpio_arready_i(gpio_arready),
		.gpio_rdata_i(gpio_rdata),
		.gpio_rresp_i(gpio_rresp),
		.gpio_rvalid_i(gpio_rvalid),
		.gpio_rready_o(gpio_rready),
		.*
	);

	bram_axi #(.MEM_ADDR_SIZE(MEM_ADDR_SIZE)) mem (
		.clk_i(clk_i),
		.rst_n_i(rst_n_i),
		.awaddr_i(mem_awaddr),
		.awvalid_i(mem_awvalid),
		.awready_o(mem_awready),
		.wdata_i(mem_wdata),
		.wstrb_i(mem_wstrb),
		.wvalid_i(mem_wvalid),
		.wready_o(mem_wready),
		.bresp_o(mem_bresp),
		.bvalid_o(mem_bvalid),
		.bready_i(mem_bready),
		.araddr_i(mem_araddr),
		.arvalid_i(mem_arvalid),
		.arready_o(mem_arready),
		.rdata_o(mem_rdata),
		.rresp_o(mem_rresp),
		.rvalid_o(mem_rvalid),
		.rready_i(mem_rready)
	);

	gpio_axi gpio (
		.clk_i(clk_i),
		.rst_n_i(rst_n_i),
		.awaddr_i(gpio_awaddr),
		.awvalid_i(gpio_awvalid),
		.awready_o(gpio_awready),
		.wdata_i(gpio_wdata),
		.wstrb_i(gpio_wstrb),
		.wvalid_i(gpio_wvalid),
		.wready_o(gpio_wready),
		.bresp_o(gpio_bresp),
		.bvalid_o(gpio_bvalid),
		.bready_i(gpio_bready),
		.araddr_i(gpio_araddr),
		.arvalid_i(gpio_arvalid),
		.arready_o(gpio_arready),
		.rdata_o(gpio_rdata),
		.rresp_o(gpio_rresp),
		.rvalid_o(gpio_rvalid),
		.rready_i(gpio_rready),
		.sw_i(sw_i),
		.led_o(led_o)
	);

endmodule

// File: dv/soc_top_chk.sv
`timescale 1ns/1ns

module soc_top_chk import soc_pkg::*; (
	input logic  clk_i,
	input logic  rst_n_i,
	input logic  s_awready_o,
	input logic  s_wready_o,
	input resp_t s_bresp_o,
	input logic  s_bvalid_o,
	input logic  s_bready_i,
	input data_t s_rdata_o,
	input resp_t s_rresp_o,
	input logic  s_rvalid_o,
	input logic  s_rready_i
);

	int err_cnt = 0; // Failed assertions so far

	// A held response keeps its payload until accepted
	assert property (@(posedge clk_i) disable iff (!rst_n_i)
		s_bvalid_o && !s_bready_i |=> s_bvalid_o && $stable(s_bresp_o))
		else begin
			$error("write response dropped or changed before bready");
			err_cnt++;
		end

	assert property (@(posedge clk_i) disable iff (!rst_n_i)
		s_rvalid_o && !s_rready_i |=> s_rvalid_o && $stable(s_rdata_o) && $stable(s_rresp_o))
		else begin
			$error("read response dropped or changed before rready");
			err_cnt++;
		end

	// Flops settle one edge into reset
	assert property (@(posedge clk_i) !rst_n_i |=> !s_bvalid_o && !s_rvalid_o)
		else begin
			$error("response valid high during reset");
			err_cnt++;
		end

	assert property (@(posedge clk_i) disable iff (!rst_n_i) s_awready_o == s_wready_o)
		else begin
			$error("awready and wready differ");
			err_cnt++;
		end

endmodule

bind soc_top soc_top_chk chk (.*);

// File: dv/tb_soc_top.sv
`timescale 1ns/1ns

module tb_soc_top import soc_pkg::*; ();

	localparam int RESET_CYCLES    = 8;
	localparam int CYCLES_PER_CASE = 20;

	logic  clk_i;
	logic  rst_n_i;
	addr_t s_awaddr_i;
	logic  s_awvalid_i;
	logic  s_awready_o;
	data_t s_wdata_i;
	strb_t s_wstrb_i;
	logic  s_wvalid_i;
	logic  s_wready_o;
	resp_t s_bresp_o;
	logic  s_bvalid_o;
	logic  s_bready_i;
	addr_t s_araddr_i;
	logic  s_arvalid_i;
	logic  s_arready_o;
	data_t s_rdata_o;
	resp_t s_rresp_o;
	logic  s_rvalid_o;
	logic  s_rready_i;
	sw_t   sw_i;
	led_t  led_o;

	// One entry per line of the cases file
	byte   op_q[$];
	addr_t addr_q[$];
	data_t data_q[$];
	strb_t strb_q[$];
	resp_t resp_exp_q[$];
	data_t expect_q[$];

	int cycle_cnt  = 0;
	int max_cycles = 0; // Zero until the cases are loaded

	soc_top dut (.*);

	initial begin
		clk_i = 1'b0;
		forever #20 clk_i = ~clk_i;
	end

	task automatic stop_on_error(input string msg);
		$display("%s", msg);
		$display("Test failed");
		$fatal(1, "simulation stopped on error");
	endtask

	task automatic check_data(input string name, input data_t actual, input data_t expected);
		if (actual !== expected) begin
			$display("** Error at %0t ns: %s = %h, expected %h", $time, name, actual, expected);
			stop_on_error("data mismatch");
		end
	endtask

	task automatic check_resp(input string name, input resp_t actual, input resp_t expected);
		if (actual !== expected) begin
			$display("** Error at %0t ns: %s = %h, expected %h", $time, name, actual, expected);
			stop_on_error("response code mismatch");
		end
	endtask

	task automatic check_led(input string name, input led_t actual, input led_t expected);
		if (actual !== expected) begin
			$display("** Error at %0t ns: %s = %h, expected %h", $time, name, actual, expected);
			stop_on_error("LED value mismatch");
		end
	endtask

	always @(posedge clk_i) begin
		cycle_cnt++;
		if (max_cycles > 0 && cycle_cnt >= max_cycles)
			stop_on_error($sformatf("Timeout: a bus response never arrived within %0d cycles",
				max_cycles));
	end

	// Any failed protocol assertion ends the run
	always @(dut.chk.err_cnt) begin
		if (dut.chk.err_cnt != 0)
			stop_on_error("A bus protocol assertion in the bound checker failed");
	end

	task automatic load_cases();
		int    fd;
		int    n;
		string line;
		byte   op;
		addr_t a;
		data_t d;
		strb_t s;
		resp_t r;
		data_t e;
		fd = $fopen("dv/soc_cases.txt", "r");
		if (fd == 0)
			stop_on_error("Could not open the cases file dv/soc_cases.txt");
		while (!$feof(fd)) begin
			line = "";
			void'($fgets(line, fd));
			n = $sscanf(line, "%c %h %h %h %h %h", op, a, d, s, r, e);
			if (n == 6) begin // Comment and blank lines never give six fields
				if (op != "W" && op != "R" && op != "S")
					stop_on_error($sformatf("Unknown operation in cases file: %s", line));
				op_q.push_back(op);
				addr_q.push_back(a);
				data_q.push_back(d);
				strb_q.push_back(s);
				resp_exp_q.push_back(r);
				expect_q.push_back(e);
			end
		end
		$fclose(fd);
		if (op_q.size() == 0)
			stop_on_error("The cases file holds no bus operations");
	endtask

	// Called at a falling edge, returns at a falling edge
	task automatic axi_write(input addr_t addr, input data_t data, input strb_t strb,
			output resp_t resp);
		int stall;
		s_awaddr_i  = addr;
		s_wdata_i   = data;
		s_wstrb_i   = strb;
		s_awvalid_i = 1'b1;
		s_wvalid_i  = 1'b1;
		#1; // Ready is combinational on valid
		while (!(s_awready_o && s_wready_o)) begin
			@(negedge clk_i);
			#1;
		end
		@(negedge clk_i);
		s_awvalid_i = 1'b0;
		s_wvalid_i  = 1'b0;
		while (!s_bvalid_o)
			@(negedge clk_i);
		stall = $urandom % 4;
		repeat (stall) @(negedge clk_i);
		if (!s_bvalid_o)
			stop_on_error("Write response was dropped before bready was given");
		resp = s_bresp_o;
		s_bready_i = 1'b1;
		@(negedge clk_i);
		s_bready_i = 1'b0;
	endtask

	task automatic axi_read(input addr_t addr, output data_t data, output resp_t resp);
		int stall;
		s_araddr_i  = addr;
		s_arvalid_i = 1'b1;
		#1;
		while (!s_arready_o) begin
			@(negedge clk_i);
			#1;
		end
		@(negedge clk_i);
		s_arvalid_i = 1'b0;
		while (!s_rvalid_o)
			@(negedge clk_i);
		stall = $urandom % 4;
		repeat (stall) @(negedge clk_i);
		if (!s_rvalid_o)
			stop_on_error("Read response was dropped before rready was given");
		data = s_rdata_o;
		resp = s_rresp_o;
		s_rready_i = 1'b1;
		@(negedge clk_i);
		s_rready_i = 1'b0;
	endtask

	// Two cycles cover the switch synchronizer
	task automatic set_switches(input sw_t value);
		sw_i = value;
		repeat (2) @(negedge clk_i);
	endtask

	initial begin
		resp_t resp;
		data_t rdata;
		rst_n_i     = 1'b0;
		s_awaddr_i  = '0;
		s_awvalid_i = 1'b0;
		s_wdata_i   = '0;
		s_wstrb_i   = '0;
		s_wvalid_i  = 1'b0;
		s_bready_i  = 1'b0;
		s_araddr_i  = '0;
		s_arvalid_i = 1'b0;
		s_rready_i  = 1'b0;
		sw_i        = '0;
		void'($urandom(75444));
		load_cases();
		max_cycles = op_q.size() * CYCLES_PER_CASE + RESET_CYCLES;
		repeat (RESET_CYCLES) @(negedge clk_i);
		rst_n_i = 1'b1;
		@(negedge clk_i);
		check_led("led_o", led_o, '0);
		foreach (op_q[i]) begin
			case (op_q[i])
				"W": begin
					axi_write(addr_q[i], data_q[i], strb_q[i], resp);
					check_resp("s_bresp_o", resp, resp_exp_q[i]);
					check_led("led_o", led_o, led_t'(expect_q[i]));
				end
				"R": begin
					axi_read(addr_q[i], rdata, resp);
					check_resp("s_rresp_o", resp, resp_exp_q[i]);
					check_data("s_rdata_o", rdata, expect_q[i]);
				end
				default: set_switches(sw_t'(data_q[i]));
			endcase
		end
		$display("Test completed successfully");
		$finish;
	end

endmodule

// File: dv/soc_cases.txt
# Columns: op addr data strb resp expect
# Op is W R or S, all values hex, expect is led_o after W and rdata after R
W 00000000 11223344 f 0 00
R 00000000 00000000 0 0 11223344
W 00000ffc deadbeef f 0 00
R 00000ffc 00000000 0 0 deadbeef
W 00000010 a5a5a5a5 f 0 00
W 00000010 00cc0000 4 0 00
R 00000010 00000000 0 0 a5cca5a5
W 00000010 77000011 9 0 00
R 00000010 00000000 0 0 77cca511
W 00000100 12345678 f 0 00
W 00000100 0000bb00 2 0 00
R 00000100 00000000 0 0 1234bb78
W 10000004 0000003c f 0 3c
R 10000004 00000000 0 0 0000003c
W 10000004 ffffff81 1 0 81
W 10000004 000000c3 0 0 c3
R 10000004 00000000 0 0 000000c3
W 10000008 000000ff f 0 c3
R 10000008 00000000 0 0 00000000
R 1000000c 00000000 0 0 00000000
S 00000000 00000005 0 0 00
R 10000000 00000000 0 0 00000005
S 00000000 0000000a 0 0 00
R 10000000 00000000 0 0 0000000a
W 00001000 99999999 f 3 c3
R 00001000 00000000 0 3 00000000
W 10000010 000000ee f 3 c3
R 10000010 00000000 0 3 00000000
W 20000000 00000011 f 3 c3
R 20000000 00000000 0 3 00000000
R 00000000 00000000 0 0 11223344
R 00000ffc 00000000 0 0 deadbeef
R 10000004 00000000 0 0 000000c3

// File: filelist.f
rtl/soc_pkg.sv
rtl/axi_crossbar.sv
rtl/bram_axi.sv
rtl/gpio_axi.sv
rtl/soc_top.sv
dv/soc_top_chk.sv
dv/tb_soc_top.sv

// File: Bender.yml
package:
  name: soc_axi

sources:
  - rtl/soc_pkg.sv
  - rtl/axi_crossbar.sv
  - rtl/bram_axi.sv
  - rtl/gpio_axi.sv
  - rtl/soc_top.sv
  - target: simulation
    files:
      - dv/soc_top_chk.sv
      - dv/tb_soc_top.sv
